// ==== hdl/ddr3_app_pkg.sv ====
package ddr3_app_pkg;

    //**********************************************************************
    // memory user-interface widths
    //**********************************************************************

    // column address into the memory in 16-bit word units
    localparam int APP_ADDR_W = 27;

    // one burst of eight 16-bit words
    localparam int APP_DATA_W = 128;

    // index of a whole burst
    localparam int BURST_ADDR_W = 24;

    // zero column bits below the burst index
    localparam int BURST_LSB_W = APP_ADDR_W - BURST_ADDR_W;

    //**********************************************************************
    // command port types
    //**********************************************************************

    // app_cmd encodings of the memory controller
    typedef enum logic [2:0] {
        CMD_WRITE = 3'b000,
        CMD_READ  = 3'b001
    } app_cmd_e;

    // what goes onto the app_* command port
    typedef struct packed {
        logic                  en;
        app_cmd_e              cmd;
        logic [APP_ADDR_W-1:0] addr;
    } app_req_t;

    // one controller asking for one burst
    typedef struct packed {
        logic                    req;
        logic [BURST_ADDR_W-1:0] burst;
    } ctl_req_t;

endpackage

// ==== hdl/acq_pkg.sv ====
package acq_pkg;

    // readout start burst and burst count
    localparam int RD_START_W = 23;
    localparam int RD_CNT_W   = 21;

    // acquisition write side
    typedef enum logic [1:0] {
        WR_IDLE      = 2'd0,
        WR_ISSUE     = 2'd1,
        WR_DRAIN_CHK = 2'd2,
        WR_DONE      = 2'd3
    } wr_state_e;

    // readout side
    typedef enum logic [1:0] {
        RD_IDLE      = 2'd0,
        RD_ISSUE     = 2'd1,
        RD_WAIT_DATA = 2'd2,
        RD_DONE      = 2'd3
    } rd_state_e;

    // one word pushed into the read FIFO
    typedef struct packed {
        logic                                wr_en;
        logic [ddr3_app_pkg::APP_DATA_W-1:0] data;
        logic                                last;
    } rd_beat_t;

endpackage

// ==== hdl/ddr3_wr_control.sv ====
`timescale 1ns/100ps

module ddr3_wr_control (
    input  logic                   ddr3_domain_clk,
    input  logic                   rst,
    input  logic                   acq_enabled,
    input  logic                   acq_done,
    input  logic                   ddr3_wr_fifo_empty,
    input  logic                   wr_grant,
    input  logic                   app_wdf_rdy,
    output logic                   ddr3_wr_fifo_rd_en,
    output ddr3_app_pkg::ctl_req_t wr_req,
    output logic                   app_wdf_wren,
    output logic                   app_wdf_end,
    output logic                   ddr3_wr_done
);
    import ddr3_app_pkg::*;
    import acq_pkg::*;

    wr_state_e               state;
    wr_state_e               state_nxt;
    logic [BURST_ADDR_W-1:0] burst_idx;
    // command and data taken for the current burst
    logic                    cmd_done;
    logic                    dat_done;
    logic                    dat_take;
    logic                    beat_done;

    // data beat taken this cycle
    assign dat_take = app_wdf_wren && app_wdf_rdy;

    // command and data both in, in any order
    assign beat_done = (state == WR_ISSUE) && (cmd_done || wr_grant) && (dat_done || dat_take);

    //**********************************************************************
    // next state
    //**********************************************************************
    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: begin
                if (acq_enabled && !ddr3_wr_fifo_empty) begin
                    state_nxt = WR_ISSUE;
                end else if (acq_enabled && acq_done) begin
                    // nothing was ever written
                    state_nxt = WR_DONE;
                end
            end
            WR_ISSUE: begin
                if (beat_done) begin
                    state_nxt = WR_DRAIN_CHK;
                end
            end
            WR_DRAIN_CHK: begin
                // wait out the pop before trusting the empty flag
                if (!ddr3_wr_fifo_rd_en) begin
                    if (!acq_enabled) begin
                        state_nxt = WR_IDLE;
                    end else if (!ddr3_wr_fifo_empty) begin
                        state_nxt = WR_ISSUE;
                    end else if (acq_done) begin
                        state_nxt = WR_DONE;
                    end
                end
            end
            WR_DONE: begin
                // hold done until readout mode
                if (!acq_enabled) begin
                    state_nxt = WR_IDLE;
                end
            end
            default: state_nxt = WR_IDLE;
        endcase
    end

    //**********************************************************************
    // state, acceptance flags, burst index
    //**********************************************************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (rst) begin
            state              <= WR_IDLE;
            cmd_done           <= 1'b0;
            dat_done           <= 1'b0;
            burst_idx          <= '0;
            ddr3_wr_fifo_rd_en <= 1'b0;
            ddr3_wr_done       <= 1'b0;
        end else begin
            state              <= state_nxt;
            // pop the ADC FIFO once the burst is fully handed over
            ddr3_wr_fifo_rd_en <= beat_done;
            ddr3_wr_done       <= (state_nxt == WR_DONE);
            if (beat_done) begin
                cmd_done <= 1'b0;
                dat_done <= 1'b0;
            end else begin
                if (wr_grant) begin
                    cmd_done <= 1'b1;
                end
                if (dat_take) begin
                    dat_done <= 1'b1;
                end
            end
            // next burst address on every pop
            if (ddr3_wr_fifo_rd_en) begin
                burst_idx <= burst_idx + 1'b1;
            end
            // new acquisition starts at burst 0
            if (state == WR_DONE && state_nxt != WR_DONE) begin
                burst_idx <= '0;
            end
        end
    end

    // request and data strobe straight from state
    assign wr_req       = '{req: (state == WR_ISSUE) && !cmd_done, burst: burst_idx};
    assign app_wdf_wren = (state == WR_ISSUE) && !dat_done;
    // single beat per burst
    assign app_wdf_end  = app_wdf_wren;

    // back-pressure holds the command and its burst index
    a_req_held: assert property (@(posedge ddr3_domain_clk) disable iff (rst)
        wr_req.req && !wr_grant |=> wr_req.req && $stable(wr_req.burst));

    // write data strobe held until the memory takes it
    a_wdf_held: assert property (@(posedge ddr3_domain_clk) disable iff (rst)
        app_wdf_wren && !app_wdf_rdy |=> app_wdf_wren);

endmodule

// ==== hdl/ddr3_rd_control.sv ====
`timescale 1ns/100ps

module ddr3_rd_control (
    input  logic                                ddr3_domain_clk,
    input  logic                                rst,
    input  logic                                enable_reading,
    input  logic [acq_pkg::RD_START_W-1:0]      ddr3_rd_start_addr,
    input  logic [acq_pkg::RD_CNT_W-1:0]        ddr3_rd_burst_cnt,
    input  logic                                rd_grant,
    input  logic                                app_rd_data_valid,
    input  logic [ddr3_app_pkg::APP_DATA_W-1:0] app_rd_data,
    input  logic                                ddr3_rd_fifo_almost_full,
    output ddr3_app_pkg::ctl_req_t              rd_req,
    output acq_pkg::rd_beat_t                   rd_fifo,
    output logic                                reading_done
);
    import ddr3_app_pkg::*;
    import acq_pkg::*;

    rd_state_e               state;
    rd_state_e               state_nxt;
    // next burst to request
    logic [BURST_ADDR_W-1:0] rd_addr;
    logic [RD_CNT_W-1:0]     burst_cnt;
    // reads granted so far
    logic [RD_CNT_W-1:0]     issue_cnt;
    // beats returned so far
    logic [RD_CNT_W-1:0]     ret_cnt;
    logic [RD_CNT_W-1:0]     issue_nxt;
    logic [RD_CNT_W-1:0]     ret_nxt;
    logic                    start;
    // registered copy of the returned beat
    logic                    beat_wen;
    logic                    beat_last;
    logic [APP_DATA_W-1:0]   beat_data;

    // new readout only once the previous one is over
    assign start     = enable_reading && (state == RD_IDLE || state == RD_DONE);
    assign issue_nxt = issue_cnt + 1'b1;
    assign ret_nxt   = ret_cnt + 1'b1;

    //**********************************************************************
    // next state
    //**********************************************************************
    always_comb begin
        state_nxt = state;
        case (state)
            RD_IDLE, RD_DONE: begin
                if (start) begin
                    // empty readout finishes at once
                    if (ddr3_rd_burst_cnt == '0) begin
                        state_nxt = RD_DONE;
                    end else begin
                        state_nxt = RD_ISSUE;
                    end
                end
            end
            RD_ISSUE: begin
                // last read command taken
                if (rd_grant && issue_nxt == burst_cnt) begin
                    state_nxt = RD_WAIT_DATA;
                end
            end
            RD_WAIT_DATA: begin
                if (beat_wen && beat_last) begin
                    state_nxt = RD_DONE;
                end
            end
            default: state_nxt = RD_IDLE;
        endcase
    end

    //**********************************************************************
    // counters, address, beat control
    //**********************************************************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (rst) begin
            state        <= RD_IDLE;
            rd_addr      <= '0;
            burst_cnt    <= '0;
            issue_cnt    <= '0;
            ret_cnt      <= '0;
            beat_wen     <= 1'b0;
            beat_last    <= 1'b0;
            reading_done <= 1'b0;
        end else begin
            state        <= state_nxt;
            reading_done <= (state_nxt == RD_DONE);
            if (start) begin
                // start burst widened to a full burst index
                rd_addr   <= BURST_ADDR_W'(ddr3_rd_start_addr);
                burst_cnt <= ddr3_rd_burst_cnt;
                issue_cnt <= '0;
                ret_cnt   <= '0;
            end else begin
                if (rd_grant) begin
                    issue_cnt <= issue_nxt;
                    rd_addr   <= rd_addr + 1'b1;
                end
                if (app_rd_data_valid) begin
                    ret_cnt <= ret_nxt;
                end
            end
            // every returned beat goes to the read FIFO one cycle later
            beat_wen  <= app_rd_data_valid;
            beat_last <= app_rd_data_valid && (ret_nxt == burst_cnt);
        end
    end

    // read data payload
    always_ff @(posedge ddr3_domain_clk) begin
        if (app_rd_data_valid) begin
            beat_data <= app_rd_data;
        end
    end

    // no new reads while the read FIFO is nearly full
    assign rd_req  = '{req: (state == RD_ISSUE) && !ddr3_rd_fifo_almost_full, burst: rd_addr};
    assign rd_fifo = '{wr_en: beat_wen, data: beat_data, last: beat_last};

    // memory returns only what was requested
    a_no_extra_beat: assert property (@(posedge ddr3_domain_clk) disable iff (rst)
        app_rd_data_valid |-> ret_cnt < burst_cnt);

endmodule

// ==== hdl/ddr3_cmd_arbiter.sv ====
`timescale 1ns/100ps

module ddr3_cmd_arbiter (
    input  logic                   ddr3_domain_clk,
    input  logic                   rst,
    input  logic                   acq_enabled,
    input  ddr3_app_pkg::ctl_req_t wr_req,
    input  ddr3_app_pkg::ctl_req_t rd_req,
    input  logic                   app_rdy,
    output logic                   wr_grant,
    output logic                   rd_grant,
    output ddr3_app_pkg::app_req_t app_req
);
    import ddr3_app_pkg::*;

    // high for acquisition writes, low for readout
    logic     wr_mode;
    logic     both_idle;
    // request of the side that owns the port
    ctl_req_t sel;

    assign both_idle = !wr_req.req && !rd_req.req;

    //**********************************************************************
    // mode register
    //**********************************************************************
    always_ff @(posedge ddr3_domain_clk) begin
        if (rst) begin
            wr_mode <= 1'b0;
        end else if (both_idle) begin
            // never switch under a pending command
            wr_mode <= acq_enabled;
        end
    end

    //**********************************************************************
    // command port mux
    //**********************************************************************
    always_comb begin
        if (wr_mode) begin
            sel         = wr_req;
            app_req.cmd = CMD_WRITE;
        end else begin
            sel         = rd_req;
            app_req.cmd = CMD_READ;
        end
        app_req.en   = sel.req;
        // burst index to column address
        app_req.addr = {sel.burst, {BURST_LSB_W{1'b0}}};
    end

    // command taken when the memory is ready
    assign wr_grant = wr_mode && wr_req.req && app_rdy;
    assign rd_grant = !wr_mode && rd_req.req && app_rdy;

    // a pending request always belongs to the side that owns the port
    a_owner_req: assert property (@(posedge ddr3_domain_clk) disable iff (rst)
        !(wr_req.req && !wr_mode) && !(rd_req.req && wr_mode));

endmodule

// ==== hdl/ddr3_intf.sv ====
`timescale 1ns/100ps

module ddr3_intf (
    input  logic                                ddr3_domain_clk,
    input  logic                                rst,
    // acquisition side
    input  logic                                acq_enabled,
    input  logic                                acq_done,
    input  logic                                ddr3_wr_fifo_empty,
    input  logic [ddr3_app_pkg::APP_DATA_W-1:0] ddr3_wr_fifo_dat,
    output logic                                ddr3_wr_fifo_rd_en,
    output logic                                ddr3_wr_done,
    // readout side
    input  logic                                enable_reading,
    input  logic [acq_pkg::RD_START_W-1:0]      ddr3_rd_start_addr,
    input  logic [acq_pkg::RD_CNT_W-1:0]        ddr3_rd_burst_cnt,
    input  logic                                ddr3_rd_fifo_almost_full,
    output acq_pkg::rd_beat_t                   rd_fifo,
    output logic                                reading_done,
    // memory command port
    output ddr3_app_pkg::app_req_t              app_req,
    input  logic                                app_rdy,
    // memory write data port
    output logic [ddr3_app_pkg::APP_DATA_W-1:0] app_wdf_data,
    output logic                                app_wdf_wren,
    output logic                                app_wdf_end,
    input  logic                                app_wdf_rdy,
    // memory read data port
    input  logic [ddr3_app_pkg::APP_DATA_W-1:0] app_rd_data,
    input  logic                                app_rd_data_valid
);
    import ddr3_app_pkg::*;

    ctl_req_t wr_req;
    ctl_req_t rd_req;
    logic     wr_grant;
    logic     rd_grant;

    // ADC FIFO head is the write data
    assign app_wdf_data = ddr3_wr_fifo_dat;

    //**********************************************************************
    // acquisition writes
    //**********************************************************************
    ddr3_wr_control wr_control0 (
        .ddr3_domain_clk   (ddr3_domain_clk),
        .rst               (rst),
        .acq_enabled       (acq_enabled),
        .acq_done          (acq_done),
        .ddr3_wr_fifo_empty(ddr3_wr_fifo_empty),
        .wr_grant          (wr_grant),
        .app_wdf_rdy       (app_wdf_rdy),
        .ddr3_wr_fifo_rd_en(ddr3_wr_fifo_rd_en),
        .wr_req            (wr_req),
        .app_wdf_wren      (app_wdf_wren),
        .app_wdf_end       (app_wdf_end),
        .ddr3_wr_done      (ddr3_wr_done)
    );

    //**********************************************************************
    // readout
    //**********************************************************************
    ddr3_rd_control rd_control0 (
        .ddr3_domain_clk         (ddr3_domain_clk),
        .rst                     (rst),
        .enable_reading          (enable_reading),
        .ddr3_rd_start_addr      (ddr3_rd_start_addr),
        .ddr3_rd_burst_cnt       (ddr3_rd_burst_cnt),
        .rd_grant                (rd_grant),
        .app_rd_data_valid       (app_rd_data_valid),
        .app_rd_data             (app_rd_data),
        .ddr3_rd_fifo_almost_full(ddr3_rd_fifo_almost_full),
        .rd_req                  (rd_req),
        .rd_fifo                 (rd_fifo),
        .reading_done            (reading_done)
    );

    // single command port shared by both controllers
    ddr3_cmd_arbiter cmd_arbiter0 (
        .ddr3_domain_clk(ddr3_domain_clk),
        .rst            (rst),
        .acq_enabled    (acq_enabled),
        .wr_req         (wr_req),
        .rd_req         (rd_req),
        .app_rdy        (app_rdy),
        .wr_grant       (wr_grant),
        .rd_grant       (rd_grant),
        .app_req        (app_req)
    );

endmodule

// ==== testbench/ddr3_app_model.sv ====
`timescale 1ns/100ps

module ddr3_app_model (
    input  logic                                ddr3_domain_clk,
    input  logic                                rst,
    input  logic [31:0]                         stall_seed,
    input  ddr3_app_pkg::app_req_t              app_req,
    output logic                                app_rdy,
    input  logic [ddr3_app_pkg::APP_DATA_W-1:0] app_wdf_data,
    input  logic                                app_wdf_wren,
    input  logic                                app_wdf_end,
    output logic                                app_wdf_rdy,
    output logic [ddr3_app_pkg::APP_DATA_W-1:0] app_rd_data,
    output logic                                app_rd_data_valid
);
    import ddr3_app_pkg::*;

    localparam int MEM_BURSTS = 1024;
    // cycles from read command to returned beat
    localparam int RD_LATENCY = 6;

    // one entry per burst at the column address divided by eight
    logic [APP_DATA_W-1:0] mem [0:MEM_BURSTS-1];
    // write commands and data beats not yet paired
    int                    wr_addr_q[$];
    logic [APP_DATA_W-1:0] wr_data_q[$];
    // outstanding reads returned in order
    int                    rd_addr_q[$];
    int                    rd_due_q[$];
    int                    cycle;
    integer                seed;

    initial begin
        // fill pattern from the whole burst index
        for (int i = 0; i < MEM_BURSTS; i++) begin
            mem[i] = {4{32'(i) ^ 32'h5aa5_c33c}};
        end
        app_rdy           = 1'b0;
        app_wdf_rdy       = 1'b0;
        app_rd_data       = '0;
        app_rd_data_valid = 1'b0;
        cycle             = 0;
    end

    // commands and write data taken on the rising edge
    always @(posedge ddr3_domain_clk) begin
        if (!rst) begin
            cycle++;
            if (app_req.en && app_rdy) begin
                if (app_req.cmd == CMD_WRITE) begin
                    wr_addr_q.push_back(int'(app_req.addr[APP_ADDR_W-1:BURST_LSB_W]) % MEM_BURSTS);
                end else begin
                    rd_addr_q.push_back(int'(app_req.addr[APP_ADDR_W-1:BURST_LSB_W]) % MEM_BURSTS);
                    rd_due_q.push_back(cycle + RD_LATENCY);
                end
            end
            // a burst is one beat so each beat must carry its end flag
            if (app_wdf_wren && app_wdf_end && app_wdf_rdy) begin
                wr_data_q.push_back(app_wdf_data);
            end
            // command and data may come in either order
            if (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
                mem[wr_addr_q.pop_front()] = wr_data_q.pop_front();
            end
        end
    end

    // ready strobes and read data change on the falling edge
    always @(negedge ddr3_domain_clk) begin
        if (rst) begin
            seed              = stall_seed;
            app_rdy           = 1'b0;
            app_wdf_rdy       = 1'b0;
            app_rd_data_valid = 1'b0;
        end else begin
            // ready about three cycles out of four
            app_rdy     = ($random(seed) & 3) != 0;
            app_wdf_rdy = ($random(seed) & 3) != 0;
            if (rd_due_q.size() > 0 && cycle >= rd_due_q[0]) begin
                app_rd_data_valid = 1'b1;
                app_rd_data       = mem[rd_addr_q.pop_front()];
                rd_due_q.delete(0);
            end else begin
                app_rd_data_valid = 1'b0;
            end
        end
    end

endmodule

// ==== testbench/tb_ddr3_intf.sv ====
`timescale 1ns/100ps

module tb_ddr3_intf;
    import ddr3_app_pkg::*;
    import acq_pkg::*;

    localparam int CLK_HALF      = 4;
    localparam int RST_CYCLES    = 10;
    localparam int MEM_BURSTS    = 1024;
    // watchdog budget per burst
    localparam int CYC_PER_BURST = 200;

    logic                      ddr3_domain_clk;
    logic                      rst;
    logic                      acq_enabled;
    logic                      acq_done;
    logic                      ddr3_wr_fifo_empty;
    logic [APP_DATA_W-1:0]     ddr3_wr_fifo_dat;
    logic                      ddr3_wr_fifo_rd_en;
    logic                      ddr3_wr_done;
    logic                      enable_reading;
    logic [RD_START_W-1:0]     ddr3_rd_start_addr;
    logic [RD_CNT_W-1:0]       ddr3_rd_burst_cnt;
    logic                      ddr3_rd_fifo_almost_full;
    rd_beat_t                  rd_fifo;
    logic                      reading_done;
    app_req_t                  app_req;
    logic                      app_rdy;
    logic [APP_DATA_W-1:0]     app_wdf_data;
    logic                      app_wdf_wren;
    logic                      app_wdf_end;
    logic                      app_wdf_rdy;
    logic [APP_DATA_W-1:0]     app_rd_data;
    logic                      app_rd_data_valid;

    // word k of an acquisition belongs at burst k
    logic [APP_DATA_W-1:0]     exp_mem [0:MEM_BURSTS-1];
    integer                    seed;
    int                        pop_cnt = 0;
    int                        adc_len = 0;
    int                        beat_cnt = 0;
    int                        rd_start = 0;
    int                        rd_cnt = 0;
    int                        timeout_cycles = 0;
    logic                      reading = 1'b0;
    logic                      done_q = 1'b0;
    logic                      en_q = 1'b0;
    logic                      wr_done_q = 1'b0;
    // one entry per case line
    int                        n_q[$];
    int                        s_q[$];
    int                        c_q[$];
    int                        af_q[$];
    int                        sd_q[$];

    ddr3_intf dut0 (.*);
    ddr3_app_model mdl0 (.*, .stall_seed(seed));

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [APP_DATA_W-1:0] got,
                               input logic [APP_DATA_W-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0d ns: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    initial begin
        ddr3_domain_clk = 1'b0;
        forever #CLK_HALF ddr3_domain_clk = ~ddr3_domain_clk;
    end

    //**********************************************************************
    // ADC FIFO model whose head and empty flag follow the pop count
    //**********************************************************************
    always @(negedge ddr3_domain_clk) begin
        ddr3_wr_fifo_empty = (pop_cnt >= adc_len);
        ddr3_wr_fifo_dat   = exp_mem[pop_cnt % MEM_BURSTS];
    end

    //**********************************************************************
    // monitors on the rising edge
    //**********************************************************************
    always @(posedge ddr3_domain_clk) begin
        if (!rst) begin
            if (ddr3_wr_fifo_rd_en) begin
                if (pop_cnt >= adc_len) begin
                    abort_run("the ADC FIFO was popped while empty");
                end
                pop_cnt++;
            end
            // done only with acq_done and nothing left in the FIFO
            if (ddr3_wr_done && !(acq_done && ddr3_wr_fifo_empty)) begin
                abort_run("ddr3_wr_done is high without acq_done and an empty FIFO");
            end
            if (wr_done_q && !ddr3_wr_done && acq_enabled) begin
                abort_run("ddr3_wr_done fell while acq_enabled was still high");
            end
            // column address is the burst index over three zero bits
            if (app_req.en && app_rdy) begin
                check_value("app_req.addr low bits", app_req.addr[BURST_LSB_W-1:0], '0);
            end
            // mode separation on accepted commands
            if (app_req.en && app_rdy && app_req.cmd == CMD_READ && acq_enabled) begin
                abort_run("a read command reached the memory during acquisition");
            end
            if (app_req.en && app_rdy && app_req.cmd == CMD_WRITE && reading) begin
                abort_run("a write command reached the memory during readout");
            end
            if (app_req.en && app_req.cmd == CMD_READ && ddr3_rd_fifo_almost_full) begin
                abort_run("a read command was issued while the read FIFO was almost full");
            end
            if (rd_fifo.wr_en) begin
                if (!reading || beat_cnt >= rd_cnt) begin
                    abort_run("a beat was pushed into the read FIFO outside a readout");
                end
                check_value("rd_fifo.data", rd_fifo.data,
                            exp_mem[(rd_start + beat_cnt) % MEM_BURSTS]);
                check_value("rd_fifo.last", rd_fifo.last, beat_cnt + 1 == rd_cnt);
                beat_cnt++;
            end
            // reading_done rises after the last beat and holds until the next start
            if (reading_done && !done_q && beat_cnt != rd_cnt) begin
                abort_run("reading_done rose before the last beat");
            end
            if (done_q && !reading_done && !en_q) begin
                abort_run("reading_done dropped without a new enable_reading");
            end
            done_q    = reading_done;
            en_q      = enable_reading;
            wr_done_q = ddr3_wr_done;
        end
    end

    task automatic write_phase(input int n);
        for (int k = 0; k < n; k++) begin
            exp_mem[k] = {$random(seed), $random(seed), $random(seed), $random(seed)};
        end
        pop_cnt = 0;
        adc_len = n;
        @(negedge ddr3_domain_clk);
        acq_enabled = 1'b1;
        while (pop_cnt < n) @(negedge ddr3_domain_clk);
        acq_done = 1'b1;
        while (!ddr3_wr_done) @(negedge ddr3_domain_clk);
        acq_enabled = 1'b0;
        while (ddr3_wr_done) @(negedge ddr3_domain_clk);
        acq_done = 1'b0;
        // burst k sits at column address 8k
        for (int k = 0; k < n; k++) begin
            check_value($sformatf("memory burst %0d", k), mdl0.mem[k], exp_mem[k]);
        end
    endtask

    task automatic read_phase(input int start, input int cnt, input int af_cycles);
        ddr3_rd_start_addr = RD_START_W'(start);
        ddr3_rd_burst_cnt  = RD_CNT_W'(cnt);
        rd_start           = start;
        rd_cnt             = cnt;
        beat_cnt           = 0;
        reading            = 1'b1;
        enable_reading     = 1'b1;
        @(negedge ddr3_domain_clk);
        enable_reading = 1'b0;
        if (af_cycles != 0) begin
            // stall with reads still in flight
            repeat (3) @(negedge ddr3_domain_clk);
            ddr3_rd_fifo_almost_full = 1'b1;
            repeat (af_cycles) @(negedge ddr3_domain_clk);
            ddr3_rd_fifo_almost_full = 1'b0;
        end
        while (!reading_done) @(negedge ddr3_domain_clk);
        check_value("rd_fifo beats", beat_cnt, cnt);
        reading = 1'b0;
    endtask

    initial begin
        int     fd;
        int     code;
        string  line;
        int     n_w;
        int     s_a;
        int     c_b;
        int     af_c;
        integer sd;
        int     total;
        rst                      = 1'b1;
        acq_enabled              = 1'b0;
        acq_done                 = 1'b0;
        ddr3_wr_fifo_empty       = 1'b1;
        ddr3_wr_fifo_dat         = '0;
        enable_reading           = 1'b0;
        ddr3_rd_start_addr       = '0;
        ddr3_rd_burst_cnt        = '0;
        ddr3_rd_fifo_almost_full = 1'b0;
        seed                     = 32'hea45_fd00;
        total                    = 0;
        fd = $fopen("testbench/ddr3_cases.txt", "r");
        if (fd == 0) begin
            abort_run("the case file testbench/ddr3_cases.txt could not be opened");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // comment and blank lines fall through the scan
            if (code > 0 && line[0] != "#" &&
                $sscanf(line, "%d %d %d %d %h", n_w, s_a, c_b, af_c, sd) == 5) begin
                n_q.push_back(n_w);
                s_q.push_back(s_a);
                c_q.push_back(c_b);
                af_q.push_back(af_c);
                sd_q.push_back(sd);
                total += n_w + c_b + 1;
            end
        end
        $fclose(fd);
        timeout_cycles = RST_CYCLES + CYC_PER_BURST * total;
        repeat (RST_CYCLES) @(negedge ddr3_domain_clk);
        rst = 1'b0;
        for (int i = 0; i < n_q.size(); i++) begin
            seed = sd_q[i];
            write_phase(n_q[i]);
            read_phase(s_q[i], c_q[i], af_q[i]);
        end
        $display("Result: PASSED");
        $finish;
    end

    // watchdog armed once the cases are known
    initial begin
        wait (timeout_cycles > 0);
        repeat (timeout_cycles) @(posedge ddr3_domain_clk);
        abort_run("the watchdog expired before all cases finished");
    end

endmodule

// ==== testbench/ddr3_cases.txt ====
# columns: write words, readout start burst, readout bursts, almost-full cycles, seed (hex)
# almost-full cycles 0 means the read FIFO never asks to stall
8    0    8    0    ea45fd00
16   4    10   0    1f2e3d4c
32   0    32   12   5a17c0de
1    0    1    0    0badf00d
40   7    25   20   3c4d5e6f
0    3    5    0    77aa1234
24   20   4    6    9e3779b9
12   0    0    0    c001d00d
20   2    18   9    13572468

// ==== vlog.f ====
hdl/ddr3_app_pkg.sv
hdl/acq_pkg.sv
hdl/ddr3_wr_control.sv
hdl/ddr3_rd_control.sv
hdl/ddr3_cmd_arbiter.sv
hdl/ddr3_intf.sv
testbench/ddr3_app_model.sv
testbench/tb_ddr3_intf.sv

// ==== Bender.yml ====
package:
  name: ddr3_intf

sources:
  - files:
      - hdl/ddr3_app_pkg.sv
      - hdl/acq_pkg.sv
      - hdl/ddr3_wr_control.sv
      - hdl/ddr3_rd_control.sv
      - hdl/ddr3_cmd_arbiter.sv
      - hdl/ddr3_intf.sv
  - target: test
    files:
      - testbench/ddr3_app_model.sv
      - testbench/tb_ddr3_intf.sv
